// ==== hdl/mcore_pkg.sv ====
package mcore_pkg;

  // word and address sizes
  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;
  // rank 0 is an inactive core
  localparam int RANK_W = 2;

  // command word field positions
  localparam int OP_LSB   = 28;
  localparam int COND_LSB = 16;
  localparam int SRC1_LSB = 8;
  localparam int SRC0_LSB = 0;

  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_HALT = 4'hf
  } op_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_START_MSG,
    ST_READ_CMD,
    ST_READ_COND,
    ST_READ_SRC1,
    ST_READ_SRC0,
    ST_EXEC,
    ST_WRITE_DST,
    ST_END_MSG,
    ST_DONE
  } core_state_e;

  // broadcast message codes
  typedef enum logic [1:0] {
    MSG_NONE  = 2'd0,
    MSG_START = 2'd1,
    MSG_END   = 2'd2
  } msg_e;

endpackage

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  logic                        cmd_load,
  input  logic [mcore_pkg::DATA_W-1:0] cmd_word,
  output mcore_pkg::op_e              op,
  output logic [mcore_pkg::ADDR_W-1:0] cond_addr,
  output logic [mcore_pkg::ADDR_W-1:0] src1_addr,
  output logic [mcore_pkg::ADDR_W-1:0] src0_addr
);

  import mcore_pkg::*;

  // current command, held until the next command read completes
  logic [DATA_W-1:0] cmd_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cmd_q <= '0;
    end else if (cmd_load) begin
      cmd_q <= cmd_word;
    end
  end

  // field split
  assign op        = op_e'(cmd_q[OP_LSB +: 4]);
  // destination shares the condition address
  assign cond_addr = cmd_q[COND_LSB +: ADDR_W];
  assign src1_addr = cmd_q[SRC1_LSB +: ADDR_W];
  assign src0_addr = cmd_q[SRC0_LSB +: ADDR_W];

endmodule

// ==== hdl/alu_result.sv ====
`timescale 1ns/1ps

module alu_result (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  logic                        src1_load,
  input  logic                        src0_load,
  input  logic [mcore_pkg::DATA_W-1:0] rdata,
  input  mcore_pkg::op_e              op,
  output logic [mcore_pkg::DATA_W-1:0] dst_word
);

  import mcore_pkg::*;

  logic [DATA_W-1:0] src1_q;
  logic [DATA_W-1:0] src0_q;

  // sources land one at a time from the read data
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      src1_q <= '0;
      src0_q <= '0;
    end else begin
      if (src1_load) begin
        src1_q <= rdata;
      end
      if (src0_load) begin
        src0_q <= rdata;
      end
    end
  end

  always_comb begin
    case (op)
      OP_ADD:  dst_word = src1_q + src0_q;
      // src1 minus src0
      OP_SUB:  dst_word = src1_q - src0_q;
      OP_AND:  dst_word = src1_q & src0_q;
      OP_OR:   dst_word = src1_q | src0_q;
      OP_XOR:  dst_word = src1_q ^ src0_q;
      default: dst_word = '0;
    endcase
  end

endmodule

// ==== hdl/core_seq.sv ====
`timescale 1ns/1ps

module core_seq (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  logic                        start,
  input  logic [mcore_pkg::ADDR_W-1:0] base_addr,
  input  logic [mcore_pkg::DATA_W-1:0] rdata,
  input  logic                        read_dn,
  input  logic                        write_dn,
  input  logic                        msg_dn,
  output mcore_pkg::core_state_e      state,
  output logic                        read_q,
  output logic                        write_q,
  output logic [mcore_pkg::ADDR_W-1:0] addr,
  output logic [mcore_pkg::DATA_W-1:0] wdata,
  output logic                        msg_q,
  output logic                        done
);

  import mcore_pkg::*;

  op_e               op;
  logic [ADDR_W-1:0] cond_addr;
  logic [ADDR_W-1:0] src1_addr;
  logic [ADDR_W-1:0] src0_addr;
  logic [DATA_W-1:0] dst_word;
  logic              cmd_load;
  logic              src1_load;
  logic              src0_load;
  // next command address
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] wdata_q;

  cmd_decode u_dec (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .cmd_load  (cmd_load),
    .cmd_word  (rdata),
    .op        (op),
    .cond_addr (cond_addr),
    .src1_addr (src1_addr),
    .src0_addr (src0_addr)
  );

  alu_result u_alu (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .src1_load (src1_load),
    .src0_load (src0_load),
    .rdata     (rdata),
    .op        (op),
    .dst_word  (dst_word)
  );

  // stage loads fire with the matching read pulse
  assign cmd_load  = (state == ST_READ_CMD) && read_dn;
  assign src1_load = (state == ST_READ_SRC1) && read_dn;
  assign src0_load = (state == ST_READ_SRC0) && read_dn;

  assign msg_q   = (state == ST_START_MSG) || (state == ST_END_MSG);
  assign write_q = (state == ST_WRITE_DST);
  assign wdata   = wdata_q;

  // request level and address per state
  always_comb begin
    read_q = 1'b0;
    addr   = cmd_addr;
    case (state)
      ST_READ_CMD: begin
        read_q = 1'b1;
      end
      ST_READ_COND: begin
        // halt reads nothing more
        read_q = (op != OP_HALT);
        addr   = cond_addr;
      end
      ST_READ_SRC1: begin
        read_q = 1'b1;
        addr   = src1_addr;
      end
      ST_READ_SRC0: begin
        read_q = 1'b1;
        addr   = src0_addr;
      end
      ST_WRITE_DST: begin
        addr = cond_addr;
      end
      default: begin
        read_q = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      // one cycle pulse on entry to done
      done <= (state == ST_END_MSG) && msg_dn;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_START_MSG;
          end
        end
        ST_START_MSG: begin
          if (msg_dn) begin
            state <= ST_READ_CMD;
          end
        end
        ST_READ_CMD: begin
          if (read_dn) begin
            state <= ST_READ_COND;
          end
        end
        ST_READ_COND: begin
          if (op == OP_HALT) begin
            state <= ST_END_MSG;
          end else if (read_dn) begin
            // zero condition skips to the next command
            state <= (rdata == '0) ? ST_READ_CMD : ST_READ_SRC1;
          end
        end
        ST_READ_SRC1: begin
          if (read_dn) begin
            state <= ST_READ_SRC0;
          end
        end
        ST_READ_SRC0: begin
          if (read_dn) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          state <= ST_WRITE_DST;
        end
        ST_WRITE_DST: begin
          if (write_dn) begin
            state <= ST_READ_CMD;
          end
        end
        ST_END_MSG: begin
          if (msg_dn) begin
            state <= ST_DONE;
          end
        end
        default: begin
          // wait for start to drop before rearming
          if (!start) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // command pointer and result word
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      cmd_addr <= base_addr;
    end else if (cmd_load) begin
      cmd_addr <= cmd_addr + 1'b1;
    end
    if (state == ST_EXEC) begin
      wdata_q <= dst_word;
    end
  end

endmodule

// ==== hdl/outside_bridge.sv ====
`timescale 1ns/1ps

module outside_bridge #(
  parameter  int NUM_CORES = 2,
  parameter  int CORE_ID   = 0,
  localparam int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input  logic                        clk,
  input  logic                        ext_rst_b,
  input  mcore_pkg::core_state_e      state,
  input  logic                        read_q,
  input  logic                        write_q,
  input  logic                        msg_q,
  input  logic                        gnt,
  input  logic                        msg_valid,
  input  logic [CORE_W-1:0]           msg_core,
  input  mcore_pkg::msg_e             msg_code,
  input  logic [mcore_pkg::DATA_W-1:0] mem_rdata,
  output logic                        bus_req,
  output logic                        bus_we,
  output logic                        read_dn,
  output logic                        write_dn,
  output logic                        msg_dn,
  output logic                        msg_req,
  output mcore_pkg::msg_e             msg_req_code,
  output logic [mcore_pkg::DATA_W-1:0] rdata,
  output logic [mcore_pkg::RANK_W-1:0] rank
);

  import mcore_pkg::*;

  logic                 rd_state;
  logic                 wr_state;
  logic                 msg_state;
  // granted access still waiting for its done pulse
  logic                 pend;
  logic                 rd_dn_q;
  logic                 wr_dn_q;
  logic [RANK_W-1:0]    act;
  logic [NUM_CORES-1:0] active_mask;
  // cores that started before this one and are still running
  logic [NUM_CORES-1:0] ahead;

  assign rd_state  = state inside {ST_READ_CMD, ST_READ_COND, ST_READ_SRC1, ST_READ_SRC0};
  assign wr_state  = (state == ST_WRITE_DST);
  assign msg_state = (state == ST_START_MSG) || (state == ST_END_MSG);

  // broadcast of our own message doubles as its done
  assign msg_dn = msg_valid && (msg_core == CORE_W'(CORE_ID));
  assign pend   = rd_dn_q | wr_dn_q | msg_dn;

  // requests pass only from bus states
  assign bus_req = ((rd_state & read_q) | (wr_state & write_q)) & ~pend;
  assign bus_we  = wr_state;
  assign msg_req = msg_state & msg_q & ~pend;

  assign msg_req_code = !msg_state ? MSG_NONE :
                        (state == ST_START_MSG) ? MSG_START : MSG_END;

  assign read_dn  = rd_dn_q;
  assign write_dn = wr_dn_q;

  // memory answers in the grant cycle, done follows one cycle later
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      rd_dn_q <= 1'b0;
      wr_dn_q <= 1'b0;
    end else begin
      rd_dn_q <= gnt & bus_req & ~bus_we;
      wr_dn_q <= gnt & bus_req & bus_we;
    end
  end

  always_ff @(posedge clk) begin
    if (gnt && bus_req && !bus_we) begin
      rdata <= mem_rdata;
    end
  end

  // rank tracking from the message trace
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      act         <= '0;
      rank        <= '0;
      active_mask <= '0;
      ahead       <= '0;
    end else if (msg_valid) begin
      if (msg_code == MSG_START) begin
        act                   <= act + 1'b1;
        active_mask[msg_core] <= 1'b1;
        if (msg_dn) begin
          // count includes ourselves
          rank  <= act + 1'b1;
          ahead <= active_mask;
        end
      end else if (msg_code == MSG_END) begin
        act                   <= act - 1'b1;
        active_mask[msg_core] <= 1'b0;
        if (msg_dn) begin
          rank <= '0;
        end else if (ahead[msg_core]) begin
          // a lower rank left, move up
          rank            <= rank - 1'b1;
          ahead[msg_core] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hdl/bus_dispatcher.sv ====
`timescale 1ns/1ps

module bus_dispatcher #(
  parameter  int NUM_CORES = 2,
  localparam int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input  logic                                       clk,
  input  logic                                       ext_rst_b,
  input  logic [NUM_CORES-1:0]                       bus_req,
  input  logic [NUM_CORES-1:0]                       bus_we,
  input  logic [NUM_CORES-1:0]                       msg_req,
  input  logic [NUM_CORES-1:0][mcore_pkg::ADDR_W-1:0] addr,
  input  logic [NUM_CORES-1:0][mcore_pkg::DATA_W-1:0] wdata,
  input  mcore_pkg::msg_e [NUM_CORES-1:0]            msg_req_code,
  output logic [NUM_CORES-1:0]                       gnt,
  output logic                                       mem_en,
  output logic                                       mem_we,
  output logic [mcore_pkg::ADDR_W-1:0]               mem_addr,
  output logic [mcore_pkg::DATA_W-1:0]               mem_wdata,
  output logic                                       msg_valid,
  output logic [CORE_W-1:0]                          msg_core,
  output mcore_pkg::msg_e                            msg_code
);

  import mcore_pkg::*;

  // highest priority core this cycle
  logic [CORE_W-1:0]    ptr;
  logic [CORE_W-1:0]    sel;
  logic [NUM_CORES-1:0] req;
  logic                 hit;
  logic                 bus_grant;
  logic                 msg_grant;

  // bus traffic first, messages only on an idle bus
  assign req = (|bus_req) ? bus_req : msg_req;

  always_comb begin
    int unsigned k;
    hit = 1'b0;
    sel = '0;
    gnt = '0;
    for (int i = 0; i < NUM_CORES; i++) begin
      k = ptr + i;
      if (k >= NUM_CORES) begin
        k = k - NUM_CORES;
      end
      if (!hit && req[k]) begin
        hit = 1'b1;
        sel = CORE_W'(k);
      end
    end
    if (hit) begin
      gnt[sel] = 1'b1;
    end
  end

  assign bus_grant = hit && (|bus_req);
  assign msg_grant = hit && !(|bus_req);

  // granted core drives memory
  assign mem_en    = bus_grant;
  assign mem_we    = bus_grant && bus_we[sel];
  assign mem_addr  = addr[sel];
  assign mem_wdata = wdata[sel];

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ptr       <= '0;
      msg_valid <= 1'b0;
      msg_core  <= '0;
      msg_code  <= MSG_NONE;
    end else begin
      if (hit) begin
        // rotate past the winner
        ptr <= (sel == CORE_W'(NUM_CORES - 1)) ? '0 : sel + 1'b1;
      end
      msg_valid <= msg_grant;
      msg_core  <= msg_grant ? sel : '0;
      msg_code  <= msg_grant ? msg_req_code[sel] : MSG_NONE;
    end
  end

endmodule

// ==== hdl/shared_mem.sv ====
`timescale 1ns/1ps

module shared_mem #(
  parameter int MEM_DEPTH = 256
) (
  input  logic                        clk,
  input  logic                        mem_en,
  input  logic                        mem_we,
  input  logic [mcore_pkg::ADDR_W-1:0] mem_addr,
  input  logic [mcore_pkg::DATA_W-1:0] mem_wdata,
  output logic [mcore_pkg::DATA_W-1:0] mem_rdata,
  input  logic                        tb_we,
  input  logic [mcore_pkg::ADDR_W-1:0] tb_addr,
  input  logic [mcore_pkg::DATA_W-1:0] tb_wdata,
  output logic [mcore_pkg::DATA_W-1:0] tb_rdata
);

  import mcore_pkg::*;

  logic [DATA_W-1:0] mem [MEM_DEPTH];

  // test port wins for program loading
  always_ff @(posedge clk) begin
    if (tb_we) begin
      mem[tb_addr] <= tb_wdata;
    end else if (mem_en && mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // read within the grant cycle
  assign mem_rdata = mem[mem_addr];
  assign tb_rdata  = mem[tb_addr];

endmodule

// ==== hdl/mcore_top.sv ====
`timescale 1ns/1ps

module mcore_top #(
  parameter  int NUM_CORES = 2,
  parameter  int MEM_DEPTH = 256,
  localparam int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input  logic                                       clk,
  input  logic                                       ext_rst_b,
  input  logic [NUM_CORES-1:0]                       start,
  input  logic [NUM_CORES-1:0][mcore_pkg::ADDR_W-1:0] base_addr,
  input  logic                                       tb_we,
  input  logic [mcore_pkg::ADDR_W-1:0]               tb_addr,
  input  logic [mcore_pkg::DATA_W-1:0]               tb_wdata,
  output logic [mcore_pkg::DATA_W-1:0]               tb_rdata,
  output logic [NUM_CORES-1:0]                       done,
  output logic [NUM_CORES-1:0][mcore_pkg::RANK_W-1:0] rank,
  output logic                                       msg_valid,
  output logic [CORE_W-1:0]                          msg_core,
  output mcore_pkg::msg_e                            msg_code
);

  import mcore_pkg::*;

  // per core bus and message lines
  core_state_e                      state [NUM_CORES];
  logic [NUM_CORES-1:0]             read_q;
  logic [NUM_CORES-1:0]             write_q;
  logic [NUM_CORES-1:0]             msg_q;
  logic [NUM_CORES-1:0]             read_dn;
  logic [NUM_CORES-1:0]             write_dn;
  logic [NUM_CORES-1:0]             msg_dn;
  logic [NUM_CORES-1:0]             bus_req;
  logic [NUM_CORES-1:0]             bus_we;
  logic [NUM_CORES-1:0]             msg_req;
  logic [NUM_CORES-1:0]             gnt;
  logic [NUM_CORES-1:0][ADDR_W-1:0] addr;
  logic [NUM_CORES-1:0][DATA_W-1:0] wdata;
  logic [NUM_CORES-1:0][DATA_W-1:0] rdata;
  msg_e [NUM_CORES-1:0]             msg_req_code;

  // shared memory port
  logic              mem_en;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem_rdata;

  for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
    core_seq u_core (
      .clk       (clk),
      .ext_rst_b (ext_rst_b),
      .start     (start[g]),
      .base_addr (base_addr[g]),
      .rdata     (rdata[g]),
      .read_dn   (read_dn[g]),
      .write_dn  (write_dn[g]),
      .msg_dn    (msg_dn[g]),
      .state     (state[g]),
      .read_q    (read_q[g]),
      .write_q   (write_q[g]),
      .addr      (addr[g]),
      .wdata     (wdata[g]),
      .msg_q     (msg_q[g]),
      .done      (done[g])
    );

    outside_bridge #(
      .NUM_CORES (NUM_CORES),
      .CORE_ID   (g)
    ) u_bridge (
      .clk          (clk),
      .ext_rst_b    (ext_rst_b),
      .state        (state[g]),
      .read_q       (read_q[g]),
      .write_q      (write_q[g]),
      .msg_q        (msg_q[g]),
      .gnt          (gnt[g]),
      .msg_valid    (msg_valid),
      .msg_core     (msg_core),
      .msg_code     (msg_code),
      .mem_rdata    (mem_rdata),
      .bus_req      (bus_req[g]),
      .bus_we       (bus_we[g]),
      .read_dn      (read_dn[g]),
      .write_dn     (write_dn[g]),
      .msg_dn       (msg_dn[g]),
      .msg_req      (msg_req[g]),
      .msg_req_code (msg_req_code[g]),
      .rdata        (rdata[g]),
      .rank         (rank[g])
    );
  end

  bus_dispatcher #(
    .NUM_CORES (NUM_CORES)
  ) u_disp (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .bus_req      (bus_req),
    .bus_we       (bus_we),
    .msg_req      (msg_req),
    .addr         (addr),
    .wdata        (wdata),
    .msg_req_code (msg_req_code),
    .gnt          (gnt),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .msg_valid    (msg_valid),
    .msg_core     (msg_core),
    .msg_code     (msg_code)
  );

  shared_mem #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_mem (
    .clk       (clk),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .tb_we     (tb_we),
    .tb_addr   (tb_addr),
    .tb_wdata  (tb_wdata),
    .tb_rdata  (tb_rdata)
  );

endmodule

// ==== tests/mcore_props.sv ====
`timescale 1ns/1ps

module mcore_props #(
  parameter  int NUM_CORES = 2,
  localparam int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
  input logic                 clk,
  input logic                 ext_rst_b,
  input logic [NUM_CORES-1:0] bus_req,
  input logic [NUM_CORES-1:0] msg_req,
  input logic [NUM_CORES-1:0] gnt,
  input logic                 mem_en,
  input logic                 msg_valid,
  input logic [CORE_W-1:0]    msg_core
);

  // assertion failures so far
  int fail_cnt = 0;

  // one winner at most among the requesting cores
  a_gnt_onehot: assert property (@(posedge clk) disable iff (ext_rst_b)
    $onehot0(gnt) && ((gnt & ~(bus_req | msg_req)) == '0))
    else begin
      fail_cnt++;
      $error("gnt has more than one bit set or goes to a core without a request");
    end

  // pending bus traffic always wins the cycle
  a_bus_first: assert property (@(posedge clk) disable iff (ext_rst_b)
    (|bus_req) |-> (|(gnt & bus_req)))
    else begin
      fail_cnt++;
      $error("bus request waiting while the grant went elsewhere");
    end

  // broadcast one cycle after a message grant, from the granted core
  a_msg_follow: assert property (@(posedge clk) disable iff (ext_rst_b)
    (!(|bus_req) && (|(gnt & msg_req)))
      |=> msg_valid && ($past(gnt) == (NUM_CORES'(1) << msg_core)))
    else begin
      fail_cnt++;
      $error("message grant without a broadcast from the granted core");
    end

  // a broadcast never comes from a bus grant
  a_msg_source: assert property (@(posedge clk) disable iff (ext_rst_b)
    msg_valid |-> $past(!(|bus_req) && (|(gnt & msg_req))))
    else begin
      fail_cnt++;
      $error("broadcast without a message grant");
    end

  // memory moves exactly on a granted bus request
  a_mem_bus: assert property (@(posedge clk) disable iff (ext_rst_b)
    mem_en == (|(gnt & bus_req)))
    else begin
      fail_cnt++;
      $error("memory access does not match the bus grant");
    end

endmodule

// ==== tests/mcore_tb.sv ====
`timescale 1ns/1ps

module mcore_tb;

  import mcore_pkg::*;

  localparam int NUM_CORES = 2;
  localparam int CORE_W    = 1;
  localparam int CASE_COLS = 7;
  localparam int MAX_CASES = 32;
  // cycles allowed per case
  localparam int CASE_CYCLES = 200;

  logic                              clk = 1'b0;
  logic                              ext_rst_b;
  logic [NUM_CORES-1:0]              start;
  logic [NUM_CORES-1:0][ADDR_W-1:0]  base_addr;
  logic                              tb_we;
  logic [ADDR_W-1:0]                 tb_addr;
  logic [DATA_W-1:0]                 tb_wdata;
  logic [DATA_W-1:0]                 tb_rdata;
  logic [NUM_CORES-1:0]              done;
  logic [NUM_CORES-1:0][RANK_W-1:0]  rank;
  logic                              msg_valid;
  logic [CORE_W-1:0]                 msg_core;
  msg_e                              msg_code;

  // case table with columns core op cond src1 src0 expected pair
  logic [DATA_W-1:0] case_mem [MAX_CASES*CASE_COLS];
  int num_cases;
  int cycle_cnt = 0;
  int cycle_limit = 1000;

  // reference model of ranks and message order
  int model_rank [NUM_CORES];
  int active_cnt;
  // 0 idle, 1 started, 2 ended
  int phase [NUM_CORES];
  logic [NUM_CORES-1:0] done_seen;
  logic mon_en = 1'b0;

  int err_value = 0;
  int err_rank  = 0;
  int err_seq   = 0;
  int err_reset = 0;

  mcore_top #(
    .NUM_CORES (NUM_CORES),
    .MEM_DEPTH (256)
  ) dut0 (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .start     (start),
    .base_addr (base_addr),
    .tb_we     (tb_we),
    .tb_addr   (tb_addr),
    .tb_wdata  (tb_wdata),
    .tb_rdata  (tb_rdata),
    .done      (done),
    .rank      (rank),
    .msg_valid (msg_valid),
    .msg_core  (msg_core),
    .msg_code  (msg_code)
  );

  bind bus_dispatcher mcore_props #(.NUM_CORES(NUM_CORES)) u_props (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .bus_req   (bus_req),
    .msg_req   (msg_req),
    .gnt       (gnt),
    .mem_en    (mem_en),
    .msg_valid (msg_valid),
    .msg_core  (msg_core)
  );

  always #5 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [ADDR_W-1:0] base_of(input int c);
    // core regions are half the memory apart
    return ADDR_W'(c * 128);
  endfunction

  function automatic logic [DATA_W-1:0] case_field(input int idx, input int col);
    return case_mem[idx*CASE_COLS+col];
  endfunction

  // opcode, then cond, src1 and src0 addresses
  function automatic logic [DATA_W-1:0] make_cmd(input logic [3:0] op,
                                                 input logic [ADDR_W-1:0] cond,
                                                 input logic [ADDR_W-1:0] s1,
                                                 input logic [ADDR_W-1:0] s0);
    return {op, 4'h0, cond, s1, s0};
  endfunction

  task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(posedge clk);
    tb_we    <= 1'b1;
    tb_addr  <= a;
    tb_wdata <= d;
    @(posedge clk);
    tb_we <= 1'b0;
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    @(posedge clk);
    tb_addr <= a;
    // peek port settles by the falling edge
    @(negedge clk);
    d = tb_rdata;
  endtask

  // command, halt, condition and both sources
  task automatic load_case(input int idx);
    int c;
    logic [ADDR_W-1:0] b;
    c = int'(case_field(idx, 0));
    b = base_of(c);
    write_word(b, make_cmd(4'(case_field(idx, 1)), b + 8'h10, b + 8'h11, b + 8'h12));
    write_word(b + 8'h01, make_cmd(OP_HALT, '0, '0, '0));
    write_word(b + 8'h10, case_field(idx, 2));
    write_word(b + 8'h11, case_field(idx, 3));
    write_word(b + 8'h12, case_field(idx, 4));
  endtask

  task automatic check_case(input int idx);
    int c;
    logic [DATA_W-1:0] got;
    c = int'(case_field(idx, 0));
    read_word(base_of(c) + 8'h10, got);
    assert (got == case_field(idx, 5)) else begin
      err_value++;
      $display("[ERROR] %0t: case %0d core %0d destination %h, expected %h",
               $time, idx, c, got, case_field(idx, 5));
    end
  endtask

  task automatic run_group(input int first, input int cnt);
    logic [NUM_CORES-1:0] mask;
    int i;
    int c;
    mask = '0;
    for (i = 0; i < cnt; i++) begin
      c = int'(case_field(first + i, 0));
      load_case(first + i);
      mask[c]      = 1'b1;
      phase[c]     = 0;
      done_seen[c] = 1'b0;
    end
    @(posedge clk);
    start <= mask;
    // done pulses are caught by the monitor
    while ((done_seen & mask) != mask) @(posedge clk);
    start <= '0;
    for (i = 0; i < cnt; i++) begin
      check_case(first + i);
    end
  endtask

  // rank rule and message order for one broadcast
  task automatic apply_msg(input int c, input msg_e code);
    int j;
    if (code == MSG_START) begin
      assert (phase[c] == 0) else begin
        err_seq++;
        $display("[ERROR] %0t: core %0d sent START twice or after END", $time, c);
      end
      phase[c]      = 1;
      active_cnt    = active_cnt + 1;
      model_rank[c] = active_cnt;
    end else if (code == MSG_END) begin
      assert (phase[c] == 1) else begin
        err_seq++;
        $display("[ERROR] %0t: core %0d sent END without START", $time, c);
      end
      phase[c] = 2;
      for (j = 0; j < NUM_CORES; j++) begin
        // later starters move up
        if (j != c && model_rank[j] > model_rank[c]) begin
          model_rank[j] = model_rank[j] - 1;
        end
      end
      model_rank[c] = 0;
      active_cnt    = active_cnt - 1;
    end else begin
      err_seq++;
      $display("[ERROR] %0t: broadcast from core %0d carries no message code", $time, c);
    end
  endtask

  // trace monitor on the falling edge
  always @(negedge clk) begin
    int c;
    if (mon_en) begin
      // rank reflects all earlier broadcasts
      for (c = 0; c < NUM_CORES; c++) begin
        assert (int'(rank[c]) == model_rank[c]) else begin
          err_rank++;
          $display("[ERROR] %0t: core %0d rank %0d, expected %0d",
                   $time, c, rank[c], model_rank[c]);
        end
      end
      if (msg_valid) begin
        apply_msg(int'(msg_core), msg_code);
      end
      for (c = 0; c < NUM_CORES; c++) begin
        if (done[c]) begin
          assert (phase[c] == 2) else begin
            err_seq++;
            $display("[ERROR] %0t: core %0d done before START and END", $time, c);
          end
          done_seen[c] = 1'b1;
        end
      end
    end
  end

  initial begin
    int i;
    int cnt;
    int total;
    ext_rst_b    = 1'b1;
    start        = '0;
    base_addr[0] = base_of(0);
    base_addr[1] = base_of(1);
    tb_we        = 1'b0;
    tb_addr      = '0;
    tb_wdata     = '0;
    active_cnt   = 0;
    done_seen    = '0;
    for (i = 0; i < NUM_CORES; i++) begin
      model_rank[i] = 0;
      phase[i]      = 0;
    end
    for (i = 0; i < MAX_CASES*CASE_COLS; i++) begin
      case_mem[i] = 'x;
    end
    $readmemh("tests/mcore_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && !$isunknown(case_mem[num_cases*CASE_COLS])) begin
      num_cases++;
    end
    cycle_limit = CASE_CYCLES * num_cases + 100;

    repeat (5) @(posedge clk);
    ext_rst_b <= 1'b0;
    @(negedge clk);
    assert (done == '0 && rank == '0 && msg_valid == 1'b0) else begin
      err_reset++;
      $display("[ERROR] %0t: after reset done=%b rank=%h msg_valid=%b",
               $time, done, rank, msg_valid);
    end
    @(posedge clk);
    mon_en <= 1'b1;

    i = 0;
    while (i < num_cases) begin
      cnt = (case_field(i, 6) != 0 && i + 1 < num_cases) ? 2 : 1;
      run_group(i, cnt);
      i = i + cnt;
    end
    repeat (4) @(posedge clk);

    total = err_value + err_rank + err_seq + err_reset + dut0.u_disp.u_props.fail_cnt;
    $display("errors: value %0d, rank %0d, sequence %0d, reset %0d, assertion %0d",
             err_value, err_rank, err_seq, err_reset, dut0.u_disp.u_props.fail_cnt);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/mcore_cases.txt ====
// columns: core opcode condition src1 src0 expected pair
// condition word is also the destination preload, pair=1 runs the line with the next one
0 0 00000001 00000005 00000003 00000008 0
1 1 00000007 00000010 00000004 0000000c 0
0 2 ffffffff 0000f0f0 00ff00ff 000000f0 0
1 3 00000002 12340000 00005678 12345678 0
0 4 80000000 aaaa5555 ffff0000 55555555 0
// zero condition leaves the preload
1 0 00000000 00000011 00000022 00000000 0
0 1 00000000 00000003 00000001 00000000 0
// wrap around
0 1 00000001 00000000 00000001 ffffffff 0
1 0 00000003 ffffffff 00000002 00000001 0
// both cores together
0 0 00000001 00000100 00000023 00000123 1
1 4 00000001 0f0f0f0f 00ff00ff 0ff00ff0 0
0 3 00000009 a0000000 0000000b a000000b 1
1 1 00000004 00000064 00000014 00000050 0
0 2 00000000 ffffffff ffffffff 00000000 1
1 0 00000005 7fffffff 00000001 80000000 0

// ==== list.f ====
hdl/mcore_pkg.sv
hdl/cmd_decode.sv
hdl/alu_result.sv
hdl/core_seq.sv
hdl/outside_bridge.sv
hdl/bus_dispatcher.sv
hdl/shared_mem.sv
hdl/mcore_top.sv
tests/mcore_props.sv
tests/mcore_tb.sv
